/* armController.sv */
`default_nettype none

module armController (
  input  wire                     clk,
  input  wire                     rstN,
  // Datapath
  input  wire armCtrlPkg::instrT  instrD,
  input  wire armCtrlPkg::flagsT  aluFlagsE,
  input  wire [31:0]              aluResultE,
  // Hazard unit
  input  wire                     StallE,
  input  wire                     FlushE,
  input  wire                     StallM,
  input  wire                     StallW,
  input  wire                     FlushW,
  // Decode controls
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD,
  // Execute controls
  output logic                    aluSrcE,
  output armCtrlPkg::aluCtrlT     aluControlE,
  output logic                    branchTakenE,
  // Memory controls
  output logic                    memWriteM,
  output logic                    memtoRegM,
  output logic                    regWriteM,
  output logic [3:0]              byteMaskM,
  // Writeback controls
  output logic                    memtoRegW,
  output logic                    regWriteW,
  output logic                    pcSrcW,
  output logic                    loadByteW,
  output logic [1:0]              byteOffsetW,
  // To hazard unit
  output logic                    pcWrPendingF
);

  import armCtrlPkg::*;

  decodeCtrlT ctrlD;
  exCtrlT     ctrlE;
  flagsT      flagsFwdE;                   // NZCV seen by Execute
  flagsT      nextFlagsE;
  logic       condExE;
  logic [3:0] byteMaskE;
  logic [1:0] byteOffsetE;
  memCtrlT    memNext, memQ;
  wbCtrlT     wbNext, wbQ;

  // ==================================================
  // Decode
  // ==================================================
  instrDecoder decoder0 (
    .instrD (instrD),
    .ctrlD  (ctrlD)
  );

  assign regSrcD = ctrlD.regSrc;
  assign immSrcD = ctrlD.immSrc;

  pipeStageReg #(.payloadT(exCtrlT)) exReg0 (
    .clk  (clk),
    .rstN (rstN),
    .en   (~StallE),
    .clr  (FlushE),
    .d    (ctrlD),
    .q    (ctrlE)
  );

  // ==================================================
  // Execute
  // ==================================================
  flagUnit flags0 (
    .clk      (clk),
    .rstN     (rstN),
    .stallW   (StallW),
    .memFlags (memQ.nextFlags),
    .memSet   (memQ.setFlags),
    .wbFlags  (wbQ.nextFlags),
    .wbSet    (wbQ.setFlags),
    .flagsE   (flagsFwdE)
  );

  condCheck cond0 (
    .cond      (ctrlE.cond),
    .flags     (flagsFwdE),
    .aluFlags  (aluFlagsE),
    .setFlags  (ctrlE.setFlags),
    .condEx    (condExE),
    .nextFlags (nextFlagsE)
  );

  memAccessCtrl memAcc0 (
    .byteAccess (ctrlE.byteAccess),
    .addrLow    (aluResultE[1:0]),         // Upper address bits go to memory only
    .byteMask   (byteMaskE),
    .byteOffset (byteOffsetE)
  );

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign branchTakenE = ctrlE.branch & condExE;

  // Failed condition kills every architectural write
  always_comb begin
    memNext.memWrite   = ctrlE.memWrite & condExE;
    memNext.memtoReg   = ctrlE.memtoReg;
    memNext.regWrite   = ctrlE.regWrite & condExE;
    memNext.pcSrc      = ctrlE.pcSrc & condExE;
    memNext.setFlags   = ctrlE.setFlags & condExE;
    memNext.byteAccess = ctrlE.byteAccess;
    memNext.byteMask   = byteMaskE;
    memNext.byteOffset = byteOffsetE;
    memNext.nextFlags  = nextFlagsE;
  end

  // ==================================================
  // Memory
  // ==================================================
  pipeStageReg #(.payloadT(memCtrlT)) memReg0 (
    .clk  (clk),
    .rstN (rstN),
    .en   (~StallM),
    .clr  (1'b0),                          // Memory stage is never flushed
    .d    (memNext),
    .q    (memQ)
  );

  assign memWriteM = memQ.memWrite;
  assign memtoRegM = memQ.memtoReg;
  assign regWriteM = memQ.regWrite;
  assign byteMaskM = memQ.byteMask;

  always_comb begin
    wbNext.memtoReg   = memQ.memtoReg;
    wbNext.regWrite   = memQ.regWrite;
    wbNext.pcSrc      = memQ.pcSrc;
    wbNext.setFlags   = memQ.setFlags;
    wbNext.loadByte   = memQ.byteAccess & memQ.memtoReg;  // LDRB only
    wbNext.byteOffset = memQ.byteOffset;
    wbNext.nextFlags  = memQ.nextFlags;
  end

  // ==================================================
  // Writeback
  // ==================================================
  pipeStageReg #(.payloadT(wbCtrlT)) wbReg0 (
    .clk  (clk),
    .rstN (rstN),
    .en   (~StallW),
    .clr  (FlushW),
    .d    (wbNext),
    .q    (wbQ)
  );

  assign memtoRegW   = wbQ.memtoReg;
  assign regWriteW   = wbQ.regWrite;
  assign pcSrcW      = wbQ.pcSrc;
  assign loadByteW   = wbQ.loadByte;
  assign byteOffsetW = wbQ.byteOffset;

  // Fetch waits while any older instruction may still redirect the PC
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | memQ.pcSrc;

endmodule

`default_nettype wire

/* armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ==================================================
  // Instruction and flag types
  // ==================================================
  typedef logic [31:0] instrT;             // Raw instruction word

  typedef struct packed {
    logic n;                               // Negative
    logic z;                               // Zero
    logic c;                               // Carry
    logic v;                               // Overflow
  } flagsT;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condT;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    AND = 4'h0, EOR = 4'h1, SUB = 4'h2, RSB = 4'h3,
    ADD = 4'h4, ADC = 4'h5, SBC = 4'h6, RSC = 4'h7,
    TST = 4'h8, TEQ = 4'h9, CMP = 4'hA, CMN = 4'hB,
    ORR = 4'hC, MOV = 4'hD, BIC = 4'hE, MVN = 4'hF
  } aluCtrlT;

  // Instruction class in bits 27:26
  localparam logic [1:0] opDataProc = 2'b00;
  localparam logic [1:0] opMemory   = 2'b01;
  localparam logic [1:0] opBranch   = 2'b10;

  localparam logic [3:0] pcRegIndex = 4'd15;  // R15 as destination means a PC write

  // ==================================================
  // Stage payloads
  // ==================================================
  typedef struct packed {
    logic [1:0] regSrc;                    // Bit 1 Rd as read port 2, bit 0 PC as read port 1
    logic [1:0] immSrc;                    // Extend select
    logic       aluSrc;                    // Immediate operand
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       setFlags;                  // S bit
    logic       pcSrc;                     // Writes R15
    logic       byteAccess;                // LDRB / STRB
    aluCtrlT    aluControl;
    condT       cond;
  } decodeCtrlT;

  typedef decodeCtrlT exCtrlT;             // Same fields, held in Execute

  typedef struct packed {
    logic       memWrite;                  // Condition gated
    logic       memtoReg;
    logic       regWrite;                  // Condition gated
    logic       pcSrc;                     // Condition gated
    logic       setFlags;                  // Condition gated
    logic       byteAccess;
    logic [3:0] byteMask;
    logic [1:0] byteOffset;
    flagsT      nextFlags;
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       setFlags;
    logic       loadByte;                  // Byte load needs the aligner
    logic [1:0] byteOffset;
    flagsT      nextFlags;
  } wbCtrlT;

endpackage

`default_nettype wire

/* condCheck.sv */
`default_nettype none

module condCheck (
  input  wire armCtrlPkg::condT  cond,
  input  wire armCtrlPkg::flagsT flags,    // Forwarded NZCV
  input  wire armCtrlPkg::flagsT aluFlags, // Result flags of this instruction
  input  wire                    setFlags,
  output logic                   condEx,
  output armCtrlPkg::flagsT      nextFlags
);

  import armCtrlPkg::*;

  logic signedGe;                          // N equals V

  assign signedGe = ~(flags.n ^ flags.v);

  always_comb begin
    case (cond)
      EQ: condEx = flags.z;
      NE: condEx = ~flags.z;
      CS: condEx = flags.c;
      CC: condEx = ~flags.c;
      MI: condEx = flags.n;
      PL: condEx = ~flags.n;
      VS: condEx = flags.v;
      VC: condEx = ~flags.v;
      HI: condEx = flags.c & ~flags.z;     // Unsigned higher
      LS: condEx = ~flags.c | flags.z;
      GE: condEx = signedGe;
      LT: condEx = ~signedGe;
      GT: condEx = ~flags.z & signedGe;
      LE: condEx = flags.z | ~signedGe;
      AL: condEx = 1'b1;
      NV: condEx = 1'b0;                   // Never executes
      default: condEx = 1'b0;
    endcase
  end

  // Only an executed S instruction changes NZCV
  always_comb begin
    if (setFlags && condEx) begin
      nextFlags = aluFlags;
    end else begin
      nextFlags = flags;
    end
  end

endmodule

`default_nettype wire

/* ctrlChecker.sv */
`default_nettype none

module ctrlChecker (
  input  wire                      clk,
  input  wire                      rstN,
  // DUT inputs
  input  wire armCtrlPkg::instrT   instrD,
  input  wire armCtrlPkg::flagsT   aluFlagsE,
  input  wire [31:0]               aluResultE,
  input  wire                      StallE, FlushE, StallM, StallW, FlushW,
  // DUT outputs
  input  wire [1:0]                regSrcD, immSrcD,
  input  wire                      aluSrcE,
  input  wire armCtrlPkg::aluCtrlT aluControlE,
  input  wire                      branchTakenE, memWriteM, memtoRegM, regWriteM,
  input  wire [3:0]                byteMaskM,
  input  wire                      memtoRegW, regWriteW, pcSrcW, loadByteW,
  input  wire [1:0]                byteOffsetW,
  input  wire                      pcWrPendingF,
  // Results
  output int                       mismatchCount,
  output int                       otherCount,
  output int                       cyclesChecked
);

  timeunit 1ns;
  timeprecision 1ps;

  import armCtrlPkg::*;

  decodeCtrlT exModel;                     // Instruction held in Execute
  memCtrlT    memModel;
  wbCtrlT     wbModel;
  flagsT      flagModel;                   // Committed NZCV
  flagsT      fwdFlags;
  logic       condModel;
  decodeCtrlT decodeNow;

  // ==================================================
  // Reference rules
  // ==================================================
  function automatic logic conditionHolds(input logic [3:0] cond, input flagsT f);
    case (cond)
      4'h0: return f.z;
      4'h1: return !f.z;
      4'h2: return f.c;
      4'h3: return !f.c;
      4'h4: return f.n;
      4'h5: return !f.n;
      4'h6: return f.v;
      4'h7: return !f.v;
      4'h8: return f.c && !f.z;
      4'h9: return !f.c || f.z;
      4'hA: return f.n == f.v;
      4'hB: return f.n != f.v;
      4'hC: return !f.z && (f.n == f.v);
      4'hD: return f.z || (f.n != f.v);
      4'hE: return 1'b1;                   // AL
      default: return 1'b0;                // NV
    endcase
  endfunction

  function automatic decodeCtrlT expectDecode(input logic [31:0] ins);
    decodeCtrlT c;
    logic [3:0] opc;
    c      = '0;
    opc    = ins[24:21];
    c.cond = condT'(ins[31:28]);
    case (ins[27:26])
      2'b00: begin
        c.aluSrc     = ins[25];
        c.aluControl = aluCtrlT'(opc);
        c.setFlags   = ins[20];
        c.regWrite   = !((opc >= 4'h8) && (opc <= 4'hB));  // Compares only set flags
      end
      2'b01: begin
        if (!(ins[25] && ins[4])) begin    // Else a no-op
          c.immSrc     = 2'b01;
          c.aluSrc     = !ins[25];
          c.aluControl = ins[23] ? ADD : SUB;
          c.byteAccess = ins[22];
          c.memtoReg   = ins[20];
          c.regWrite   = ins[20];
          c.memWrite   = !ins[20];
          c.regSrc     = ins[20] ? 2'b00 : 2'b10;
        end
      end
      2'b10: begin
        c.regSrc     = 2'b01;
        c.immSrc     = 2'b10;
        c.aluSrc     = 1'b1;
        c.aluControl = ADD;
        c.branch     = 1'b1;
      end
      default: c.regWrite = 1'b0;          // Class 11 does nothing
    endcase
    c.pcSrc = ((ins[15:12] == 4'hF) && c.regWrite) || c.branch;
    return c;
  endfunction

  task automatic compareField(input string testName, input string sigName,
                              input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      mismatchCount++;
      $display("FAILED %s %s expected %0h actual %0h at %0t",
               testName, sigName, expected, actual, $time);
    end
  endtask

  // ==================================================
  // Pipeline model
  // ==================================================
  always_comb begin
    if (memModel.setFlags) begin
      fwdFlags = memModel.nextFlags;       // Nearest older setter first
    end else if (wbModel.setFlags) begin
      fwdFlags = wbModel.nextFlags;
    end else begin
      fwdFlags = flagModel;
    end
    condModel = conditionHolds(exModel.cond, fwdFlags);
  end

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exModel   <= '0;
      memModel  <= '0;
      wbModel   <= '0;
      flagModel <= '0;
    end else begin
      if (wbModel.setFlags && !StallW) flagModel <= wbModel.nextFlags;
      if (FlushW) begin
        wbModel <= '0;                     // Bubble
      end else if (!StallW) begin
        wbModel.memtoReg   <= memModel.memtoReg;
        wbModel.regWrite   <= memModel.regWrite;
        wbModel.pcSrc      <= memModel.pcSrc;
        wbModel.setFlags   <= memModel.setFlags;
        wbModel.loadByte   <= memModel.byteAccess && memModel.memtoReg;
        wbModel.byteOffset <= memModel.byteOffset;
        wbModel.nextFlags  <= memModel.nextFlags;
      end
      if (!StallM) begin
        memModel.memWrite   <= exModel.memWrite && condModel;
        memModel.memtoReg   <= exModel.memtoReg;
        memModel.regWrite   <= exModel.regWrite && condModel;
        memModel.pcSrc      <= exModel.pcSrc && condModel;
        memModel.setFlags   <= exModel.setFlags && condModel;
        memModel.byteAccess <= exModel.byteAccess;
        memModel.byteMask   <= exModel.byteAccess ? (4'b0001 << aluResultE[1:0]) : 4'b1111;
        memModel.byteOffset <= aluResultE[1:0];
        memModel.nextFlags  <= (exModel.setFlags && condModel) ? aluFlagsE : fwdFlags;
      end
      if (FlushE) begin
        exModel <= '0;
      end else if (!StallE) begin
        exModel <= expectDecode(instrD);
      end
    end
  end

  // ==================================================
  // Compare mid-cycle once inputs and outputs settle
  // ==================================================
  always @(negedge clk) begin
    decodeNow = expectDecode(instrD);
    if (!rstN) begin
      compareField("reset", "regWriteM", 0, regWriteM);
      compareField("reset", "memWriteM", 0, memWriteM);
      compareField("reset", "branchTakenE", 0, branchTakenE);
      compareField("reset", "regWriteW", 0, regWriteW);
      compareField("reset", "pcSrcW", 0, pcSrcW);
      compareField("reset", "pcWrPendingF", 0, pcWrPendingF);
    end else begin
      cyclesChecked++;
    end
    compareField("decodeD", "regSrcD", decodeNow.regSrc, regSrcD);
    compareField("decodeD", "immSrcD", decodeNow.immSrc, immSrcD);
    compareField("decodeE", "aluSrcE", exModel.aluSrc, aluSrcE);
    compareField("decodeE", "aluControlE", exModel.aluControl, aluControlE);
    compareField("condGate", "branchTakenE", exModel.branch && condModel, branchTakenE);
    compareField("condGate", "regWriteM", memModel.regWrite, regWriteM);
    compareField("condGate", "memWriteM", memModel.memWrite, memWriteM);
    compareField("memStage", "memtoRegM", memModel.memtoReg, memtoRegM);
    compareField("byteAccess", "byteMaskM", memModel.byteMask, byteMaskM);
    compareField("byteAccess", "loadByteW", wbModel.loadByte, loadByteW);
    compareField("byteAccess", "byteOffsetW", wbModel.byteOffset, byteOffsetW);
    compareField("writeback", "memtoRegW", wbModel.memtoReg, memtoRegW);
    compareField("writeback", "regWriteW", wbModel.regWrite, regWriteW);
    compareField("writeback", "pcSrcW", wbModel.pcSrc, pcSrcW);
    compareField("hazard", "pcWrPendingF",
                 decodeNow.pcSrc || exModel.pcSrc || memModel.pcSrc, pcWrPendingF);
  end

  // Reset must be released in bounded time
  initial begin
    int waitCycles;
    mismatchCount = 0;
    otherCount    = 0;
    cyclesChecked = 0;
    waitCycles    = 0;
    #1;
    while (!rstN && waitCycles < 20) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!rstN) begin
      otherCount++;
      $display("Reset was still active after 20 cycles");
    end
  end

endmodule

`default_nettype wire

/* flagUnit.sv */
`default_nettype none

module flagUnit (
  input  wire                    clk,
  input  wire                    rstN,
  input  wire                    stallW,
  input  wire armCtrlPkg::flagsT memFlags, // Pending update in Memory
  input  wire                    memSet,
  input  wire armCtrlPkg::flagsT wbFlags,  // Pending update in Writeback
  input  wire                    wbSet,
  output armCtrlPkg::flagsT      flagsE
);

  import armCtrlPkg::*;

  flagsT flagsQ;                           // Architectural NZCV

  // Commit at the end of Writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (wbSet && !stallW) begin
      flagsQ <= wbFlags;
    end
  end

  // Youngest older setter wins
  always_comb begin
    if (memSet) begin
      flagsE = memFlags;
    end else if (wbSet) begin
      flagsE = wbFlags;
    end else begin
      flagsE = flagsQ;
    end
  end

endmodule

`default_nettype wire

/* instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  wire armCtrlPkg::instrT      instrD,
  output armCtrlPkg::decodeCtrlT      ctrlD
);

  import armCtrlPkg::*;

  logic [1:0] opField;                     // Instruction class
  logic       immBit;                      // I bit, bit 25
  logic       loadBit;                     // L bit for memory, S bit for data processing
  logic       upBit;                       // U bit, add or subtract offset
  logic       byteBit;                     // B bit
  logic       badLdSt;                     // Register offset with bit 4 set
  logic       compareOp;                   // TST / TEQ / CMP / CMN
  logic [3:0] rdField;

  assign opField   = instrD[27:26];
  assign immBit    = instrD[25];
  assign loadBit   = instrD[20];
  assign upBit     = instrD[23];
  assign byteBit   = instrD[22];
  assign badLdSt   = instrD[25] & instrD[4];
  assign compareOp = (instrD[24:23] == 2'b10);  // Opcodes 10xx only set flags
  assign rdField   = instrD[15:12];

  always_comb begin
    ctrlD      = '0;                       // No-op unless a class below claims it
    ctrlD.cond = condT'(instrD[31:28]);

    case (opField)
      // ==================================================
      opDataProc: begin
        // Multiply and halfword encodings fall in here too
        ctrlD.immSrc     = 2'b00;
        ctrlD.aluSrc     = immBit;         // Rotated imm8 or register
        ctrlD.aluControl = aluCtrlT'(instrD[24:21]);
        ctrlD.setFlags   = loadBit;
        ctrlD.regWrite   = ~compareOp;
      end

      // ==================================================
      opMemory: begin
        if (!badLdSt) begin
          ctrlD.immSrc     = 2'b01;        // imm12 zero extended
          ctrlD.aluSrc     = ~immBit;      // I bit clear means immediate offset here
          ctrlD.aluControl = upBit ? ADD : SUB;
          ctrlD.byteAccess = byteBit;
          if (loadBit) begin
            ctrlD.memtoReg = 1'b1;
            ctrlD.regWrite = 1'b1;
          end else begin
            ctrlD.memWrite = 1'b1;
            ctrlD.regSrc   = 2'b10;        // Store data comes from Rd
          end
        end
      end

      // ==================================================
      opBranch: begin
        ctrlD.regSrc     = 2'b01;          // PC on port 1
        ctrlD.immSrc     = 2'b10;          // imm24 shifted
        ctrlD.aluSrc     = 1'b1;
        ctrlD.aluControl = ADD;
        ctrlD.branch     = 1'b1;
      end

      // Coprocessor and SWI space stays a no-op
      default: ctrlD.regWrite = 1'b0;
    endcase

    // PC write, either R15 as destination or a branch
    ctrlD.pcSrc = ((rdField == pcRegIndex) & ctrlD.regWrite) | ctrlD.branch;
  end

endmodule

`default_nettype wire

/* memAccessCtrl.sv */
`default_nettype none

module memAccessCtrl (
  input  wire        byteAccess,
  input  wire  [1:0] addrLow,              // Address bits 1:0
  output logic [3:0] byteMask,             // Write strobe per byte lane
  output logic [1:0] byteOffset
);

  // Little-endian lanes with lane 0 at bits 7:0
  always_comb begin
    if (byteAccess) begin
      case (addrLow)
        2'd0:    byteMask = 4'b0001;
        2'd1:    byteMask = 4'b0010;
        2'd2:    byteMask = 4'b0100;
        default: byteMask = 4'b1000;
      endcase
    end else begin
      byteMask = 4'b1111;                  // Whole word
    end
  end

  // Carried down to the load aligner
  assign byteOffset = addrLow;

endmodule

`default_nettype wire

/* pipeStageReg.sv */
`default_nettype none

module pipeStageReg #(
  parameter type payloadT = logic          // Stage payload struct
) (
  input  wire     clk,
  input  wire     rstN,
  input  wire     en,                      // Low holds the stage
  input  wire     clr,                     // Bubble insert
  input  wire payloadT d,
  output payloadT q
);

  // Clear wins over enable so a flush during a freeze still lands
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (clr) begin
      q <= '0;                             // All write bits low
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
armCtrlPkg.sv
instrDecoder.sv
pipeStageReg.sv
condCheck.sv
flagUnit.sv
memAccessCtrl.sv
armController.sv
ctrlChecker.sv
tbArmController.sv

/* tbArmController.sv */
`default_nettype none

module tbArmController;

  timeunit 1ns;
  timeprecision 1ps;

  import armCtrlPkg::*;

  localparam int numCycles = 2000;         // Random stimulus cycles

  logic        clk = 1'b0;
  logic        rstN;
  instrT       instrD;
  flagsT       aluFlagsE;
  logic [31:0] aluResultE;
  logic        StallE, FlushE, StallM, StallW, FlushW;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE;
  aluCtrlT     aluControlE;
  logic        branchTakenE, memWriteM, memtoRegM, regWriteM;
  logic [3:0]  byteMaskM;
  logic        memtoRegW, regWriteW, pcSrcW, loadByteW;
  logic [1:0]  byteOffsetW;
  logic        pcWrPendingF;
  int          mismatchCount;
  int          otherCount;
  int          cyclesChecked;
  int          timeoutCount;

  armController dut0 (.*);

  ctrlChecker ctrlChecker (.*);            // Holds the reference model

  always #50 clk = ~clk;                   // 100 ns period

  // ==================================================
  // Stimulus
  // ==================================================
  function automatic instrT randomInstr();
    instrT ins;
    int    classPick;
    ins       = $urandom;
    classPick = $urandom_range(99);
    if (classPick < 40) ins[27:26] = 2'b00;           // Data processing
    else if (classPick < 75) ins[27:26] = 2'b01;      // LDR / STR with some bad forms
    else if (classPick < 92) ins[27:26] = 2'b10;      // B
    else ins[27:26] = 2'b11;                          // No-op space
    if ($urandom_range(3) == 0) ins[31:28] = 4'hE;    // Extra AL
    if ($urandom_range(7) == 0) ins[15:12] = 4'hF;    // Rd is PC
    return ins;
  endfunction

  task automatic applyRandomInputs();
    logic freeze;
    freeze     = ($urandom_range(99) < 5);
    instrD     = randomInstr();
    aluFlagsE  = flagsT'($urandom_range(15));
    aluResultE = $urandom;
    StallE     = freeze;                   // Freeze holds all three stages
    StallM     = freeze;
    StallW     = freeze;
    FlushE     = ($urandom_range(99) < 3);
    FlushW     = ($urandom_range(99) < 3);
  endtask

  task automatic applyIdleInputs();
    instrD     = '0;
    aluFlagsE  = '0;
    aluResultE = '0;
    StallE     = 1'b0;
    StallM     = 1'b0;
    StallW     = 1'b0;
    FlushE     = 1'b0;
    FlushW     = 1'b0;
  endtask

  initial begin
    int seedValue;
    int waitCycles;
    seedValue    = $urandom(59);
    timeoutCount = 0;
    rstN         = 1'b0;
    applyIdleInputs();
    repeat (8) @(posedge clk);
    #5;
    rstN = 1'b1;
    for (int cycle = 0; cycle < numCycles; cycle++) begin
      applyRandomInputs();
      @(posedge clk);
      #5;
    end
    applyIdleInputs();

    // Drain so the last instructions reach Writeback
    waitCycles = 0;
    while (cyclesChecked < numCycles + 4 && waitCycles < 50) begin
      @(posedge clk);
      waitCycles++;
    end
    if (cyclesChecked < numCycles + 4) begin
      timeoutCount++;
      $display("Checker did not finish comparing within 50 drain cycles");
    end

    $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatchCount, otherCount, timeoutCount);
    if (mismatchCount == 0 && otherCount == 0 && timeoutCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
